// ==== logic/dual_clock_ram.sv ====
module dual_clock_ram #(
    parameter int         DEPTH = 256,
    parameter logic [7:0] FILL  = 8'h00
) (
    input  logic                     clk_core,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  logic [7:0]               wdata,
    input  logic                     clk_vga,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output logic [7:0]               rdata
);

    // starts out filled, e.g. blanks in the text buffer
    logic [7:0] mem [DEPTH] = '{default: FILL};

    // write port, core side
    always_ff @(posedge clk_core) begin
        if (we)
            mem[waddr] <= wdata;
    end

    // read port, video side, one cycle latency
    always_ff @(posedge clk_vga) begin
        rdata <= mem[raddr];
    end

endmodule

// ==== logic/text_renderer.sv ====
module text_renderer #(
    parameter int COLS       = video_timing_pkg::DEF_COLS,
    parameter int ROWS       = video_timing_pkg::DEF_ROWS,
    parameter int GLYPH_ROWS = video_timing_pkg::DEF_GLYPH_ROWS
) (
    input  logic                              clk_vga,
    input  logic                              rst,
    input  logic [$clog2(COLS)-1:0]           col,
    input  logic [$clog2(ROWS)-1:0]           row,
    input  logic [$clog2(GLYPH_ROWS)-1:0]     glyph_line,
    input  logic [2:0]                        pixel_x,
    input  logic                              active,
    input  logic                              hsync_raw,
    input  logic                              vsync_raw,
    input  logic                              frame_start,
    input  logic [7:0]                        ctl,
    input  logic [7:0]                        cursor_x,
    input  logic [7:0]                        cursor_y,
    input  logic [7:0]                        text_rdata,
    input  logic [7:0]                        font_rdata,
    output logic [$clog2(COLS*ROWS)-1:0]      text_raddr,
    output logic [$clog2(256*GLYPH_ROWS)-1:0] font_raddr,
    output logic [2:0]                        rgb,
    output logic                              hsync,
    output logic                              vsync
);
    import video_bus_pkg::*;
    import video_timing_pkg::*;

    localparam int TEXT_AW = $clog2(COLS * ROWS);
    localparam int FONT_AW = $clog2(256 * GLYPH_ROWS);

    logic [7:0] ctl_meta, ctl_sync, ctl_frame;
    logic [7:0] cx_meta, cx_sync, cx_frame;
    logic [7:0] cy_meta, cy_sync, cy_frame;
    logic [7:0] cur_x;
    logic [7:0] cur_y;

    logic [$clog2(GLYPH_ROWS)-1:0] line_s1;
    logic [2:0]                    px_s1, px_s2;
    logic                          cur_s1, cur_s2;
    logic                          act_s1, act_s2;
    logic [RENDER_LATENCY-1:0]     hs_dly, vs_dly;

    logic       pixel_on;
    logic       invert;
    logic [2:0] fg;
    logic [2:0] bg;

    // two flops from the core domain, then held for a whole frame
    always_ff @(posedge clk_vga) begin
        if (rst) begin
            ctl_meta  <= CTL_RESET;
            ctl_sync  <= CTL_RESET;
            ctl_frame <= CTL_RESET;
            cx_meta   <= '0;
            cx_sync   <= '0;
            cx_frame  <= '0;
            cy_meta   <= '0;
            cy_sync   <= '0;
            cy_frame  <= '0;
        end else begin
            ctl_meta <= ctl;
            ctl_sync <= ctl_meta;
            cx_meta  <= cursor_x;
            cx_sync  <= cx_meta;
            cy_meta  <= cursor_y;
            cy_sync  <= cy_meta;
            if (frame_start) begin
                ctl_frame <= ctl_sync;
                cx_frame  <= cx_sync;
                cy_frame  <= cy_sync;
            end
        end
    end

    // first pixel of a frame already sees the values being adopted
    assign cur_x = frame_start ? cx_sync : cx_frame;
    assign cur_y = frame_start ? cy_sync : cy_frame;

    // stage 1, character lookup
    assign text_raddr = TEXT_AW'(row * COLS + col);

    always_ff @(posedge clk_vga) begin
        line_s1 <= glyph_line;
        px_s1   <= pixel_x;
        cur_s1  <= (8'(col) == cur_x) && (8'(row) == cur_y);
    end

    // stage 2, glyph row lookup
    assign font_raddr = FONT_AW'(text_rdata * GLYPH_ROWS + line_s1);

    always_ff @(posedge clk_vga) begin
        px_s2  <= px_s1;
        cur_s2 <= cur_s1;
    end

    // stage 3, pixel select and color
    assign pixel_on = font_rdata[GLYPH_W - 1 - px_s2];
    assign invert   = cur_s2 & ctl_frame[CTL_CURSOR];
    assign fg       = ctl_frame[2:0];
    assign bg       = ctl_frame[5:3];

    always_ff @(posedge clk_vga) begin
        if (rst) begin
            act_s1 <= 1'b0;
            act_s2 <= 1'b0;
            rgb    <= '0;
            hs_dly <= '1;  // syncs idle high
            vs_dly <= '1;
        end else begin
            act_s1 <= active;
            act_s2 <= act_s1;
            if (act_s2 && ctl_frame[CTL_ENABLE])
                rgb <= (pixel_on ^ invert) ? fg : bg;
            else
                rgb <= '0;
            hs_dly <= {hs_dly[RENDER_LATENCY-2:0], hsync_raw};
            vs_dly <= {vs_dly[RENDER_LATENCY-2:0], vsync_raw};
        end
    end

    assign hsync = hs_dly[RENDER_LATENCY-1];
    assign vsync = vs_dly[RENDER_LATENCY-1];

endmodule

// ==== logic/text_video.sv ====
module text_video #(
    parameter logic [video_bus_pkg::BUS_ADDR_W-1:0] VIDEO_BASE = 32'h0001_0000,
    parameter int COLS       = video_timing_pkg::DEF_COLS,
    parameter int ROWS       = video_timing_pkg::DEF_ROWS,
    parameter int GLYPH_ROWS = video_timing_pkg::DEF_GLYPH_ROWS,
    parameter int H_FRONT    = video_timing_pkg::DEF_H_FRONT,
    parameter int H_SYNC     = video_timing_pkg::DEF_H_SYNC,
    parameter int H_BACK     = video_timing_pkg::DEF_H_BACK,
    parameter int V_FRONT    = video_timing_pkg::DEF_V_FRONT,
    parameter int V_SYNC     = video_timing_pkg::DEF_V_SYNC,
    parameter int V_BACK     = video_timing_pkg::DEF_V_BACK
) (
    input  logic                                 clk_core,
    input  logic                                 clk_vga,
    input  logic                                 rst,
    input  logic                                 strobe,
    input  logic                                 rw,
    input  logic [video_bus_pkg::BUS_ADDR_W-1:0] addr,
    input  logic [video_bus_pkg::BUS_DATA_W-1:0] data,
    output logic [2:0]                           vga_red,
    output logic [2:0]                           vga_green,
    output logic [1:0]                           vga_blue,
    output logic                                 hsync,
    output logic                                 vsync
);

    localparam int TEXT_AW = $clog2(COLS * ROWS);
    localparam int FONT_AW = $clog2(256 * GLYPH_ROWS);

    logic [7:0]                    ctl, cursor_x, cursor_y, wdata;
    logic                          text_we, font_we;
    logic [TEXT_AW-1:0]            text_waddr, text_raddr;
    logic [FONT_AW-1:0]            font_waddr, font_raddr;
    logic [7:0]                    text_rdata, font_rdata;
    logic [$clog2(COLS)-1:0]       col;
    logic [$clog2(ROWS)-1:0]       row;
    logic [$clog2(GLYPH_ROWS)-1:0] glyph_line;
    logic [2:0]                    pixel_x;
    logic                          active, hsync_raw, vsync_raw, frame_start;
    logic [2:0]                    rgb;

    video_regs #(
        .VIDEO_BASE(VIDEO_BASE), .COLS(COLS), .ROWS(ROWS), .GLYPH_ROWS(GLYPH_ROWS)
    ) u_video_regs (
        .clk_core(clk_core), .rst(rst), .strobe(strobe), .rw(rw), .addr(addr), .data(data),
        .ctl(ctl), .cursor_x(cursor_x), .cursor_y(cursor_y),
        .text_we(text_we), .text_waddr(text_waddr),
        .font_we(font_we), .font_waddr(font_waddr), .wdata(wdata)
    );

    dual_clock_ram #(.DEPTH(COLS * ROWS), .FILL(8'h20)) text_ram (  // blank screen
        .clk_core(clk_core), .we(text_we), .waddr(text_waddr), .wdata(wdata),
        .clk_vga(clk_vga), .raddr(text_raddr), .rdata(text_rdata)
    );

    dual_clock_ram #(.DEPTH(256 * GLYPH_ROWS), .FILL(8'h00)) font_ram (
        .clk_core(clk_core), .we(font_we), .waddr(font_waddr), .wdata(wdata),
        .clk_vga(clk_vga), .raddr(font_raddr), .rdata(font_rdata)
    );

    vga_timing #(
        .COLS(COLS), .ROWS(ROWS), .GLYPH_ROWS(GLYPH_ROWS),
        .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) u_vga_timing (
        .clk_vga(clk_vga), .rst(rst), .col(col), .row(row), .glyph_line(glyph_line),
        .pixel_x(pixel_x), .active(active), .hsync_raw(hsync_raw), .vsync_raw(vsync_raw),
        .frame_start(frame_start)
    );

    text_renderer #(.COLS(COLS), .ROWS(ROWS), .GLYPH_ROWS(GLYPH_ROWS)) u_text_renderer (
        .clk_vga(clk_vga), .rst(rst), .col(col), .row(row), .glyph_line(glyph_line),
        .pixel_x(pixel_x), .active(active), .hsync_raw(hsync_raw), .vsync_raw(vsync_raw),
        .frame_start(frame_start), .ctl(ctl), .cursor_x(cursor_x), .cursor_y(cursor_y),
        .text_rdata(text_rdata), .font_rdata(font_rdata),
        .text_raddr(text_raddr), .font_raddr(font_raddr),
        .rgb(rgb), .hsync(hsync), .vsync(vsync)
    );

    // one bit per color, spread to 3-3-2
    assign vga_red   = {3{rgb[2]}};
    assign vga_green = {3{rgb[1]}};
    assign vga_blue  = {2{rgb[0]}};

endmodule

// ==== logic/vga_timing.sv ====
module vga_timing #(
    parameter int COLS       = video_timing_pkg::DEF_COLS,
    parameter int ROWS       = video_timing_pkg::DEF_ROWS,
    parameter int GLYPH_ROWS = video_timing_pkg::DEF_GLYPH_ROWS,
    parameter int H_FRONT    = video_timing_pkg::DEF_H_FRONT,
    parameter int H_SYNC     = video_timing_pkg::DEF_H_SYNC,
    parameter int H_BACK     = video_timing_pkg::DEF_H_BACK,
    parameter int V_FRONT    = video_timing_pkg::DEF_V_FRONT,
    parameter int V_SYNC     = video_timing_pkg::DEF_V_SYNC,
    parameter int V_BACK     = video_timing_pkg::DEF_V_BACK
) (
    input  logic                          clk_vga,
    input  logic                          rst,
    output logic [$clog2(COLS)-1:0]       col,
    output logic [$clog2(ROWS)-1:0]       row,
    output logic [$clog2(GLYPH_ROWS)-1:0] glyph_line,
    output logic [2:0]                    pixel_x,
    output logic                          active,
    output logic                          hsync_raw,
    output logic                          vsync_raw,
    output logic                          frame_start
);
    import video_timing_pkg::*;

    localparam int H_ACTIVE = COLS * GLYPH_W;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_ACTIVE = ROWS * GLYPH_ROWS;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int HW       = $clog2(H_TOTAL);
    localparam int VW       = $clog2(V_TOTAL);
    localparam int GW       = $clog2(GLYPH_ROWS);

    logic [HW-1:0] h_cnt;
    logic [VW-1:0] v_cnt;
    logic          line_end;

    assign line_end = (h_cnt == HW'(H_TOTAL - 1));

    // cell sub-counters hold on the last active pixel through blanking
    always_ff @(posedge clk_vga) begin
        if (rst || line_end) begin
            h_cnt   <= '0;
            pixel_x <= '0;
            col     <= '0;
        end else begin
            h_cnt <= h_cnt + 1'b1;
            if (h_cnt < HW'(H_ACTIVE - 1)) begin
                pixel_x <= pixel_x + 1'b1;  // wraps at glyph edge
                if (pixel_x == 3'(GLYPH_W - 1))
                    col <= col + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_vga) begin
        if (rst || (line_end && v_cnt == VW'(V_TOTAL - 1))) begin
            v_cnt      <= '0;
            glyph_line <= '0;
            row        <= '0;
        end else if (line_end) begin
            v_cnt <= v_cnt + 1'b1;
            if (v_cnt < VW'(V_ACTIVE - 1)) begin
                if (glyph_line == GW'(GLYPH_ROWS - 1)) begin
                    glyph_line <= '0;
                    row        <= row + 1'b1;
                end else begin
                    glyph_line <= glyph_line + 1'b1;
                end
            end
        end
    end

    // active, front porch, sync, back porch
    assign active      = (h_cnt < H_ACTIVE) && (v_cnt < V_ACTIVE);
    assign hsync_raw   = !((h_cnt >= H_ACTIVE + H_FRONT) && (h_cnt < H_ACTIVE + H_FRONT + H_SYNC));
    assign vsync_raw   = !((v_cnt >= V_ACTIVE + V_FRONT) && (v_cnt < V_ACTIVE + V_FRONT + V_SYNC));
    assign frame_start = (h_cnt == '0) && (v_cnt == '0);

endmodule

// ==== logic/video_bus_pkg.sv ====
package video_bus_pkg;

    localparam int BUS_ADDR_W = 32;
    localparam int BUS_DATA_W = 32;

    // register offsets from the video base
    localparam int unsigned REG_CTL      = 0;
    localparam int unsigned REG_CURSOR_X = 1;
    localparam int unsigned REG_CURSOR_Y = 2;

    // window offsets from the video base
    localparam int unsigned TEXT_OFFSET = 'h1000;  // character buffer
    localparam int unsigned FONT_OFFSET = 'h2000;  // glyph table

    // control byte: enable, cursor, background rgb [5:3], foreground rgb [2:0]
    localparam logic [7:0] CTL_RESET = 8'h87;  // enabled, no cursor, white on black

    localparam int CTL_ENABLE = 7;
    localparam int CTL_CURSOR = 6;

endpackage

// ==== logic/video_regs.sv ====
module video_regs #(
    parameter logic [video_bus_pkg::BUS_ADDR_W-1:0] VIDEO_BASE = '0,
    parameter int COLS       = video_timing_pkg::DEF_COLS,
    parameter int ROWS       = video_timing_pkg::DEF_ROWS,
    parameter int GLYPH_ROWS = video_timing_pkg::DEF_GLYPH_ROWS
) (
    input  logic                                  clk_core,
    input  logic                                  rst,
    input  logic                                  strobe,
    input  logic                                  rw,
    input  logic [video_bus_pkg::BUS_ADDR_W-1:0]  addr,
    input  logic [video_bus_pkg::BUS_DATA_W-1:0]  data,
    output logic [7:0]                            ctl,
    output logic [7:0]                            cursor_x,
    output logic [7:0]                            cursor_y,
    output logic                                  text_we,
    output logic [$clog2(COLS*ROWS)-1:0]          text_waddr,
    output logic                                  font_we,
    output logic [$clog2(256*GLYPH_ROWS)-1:0]     font_waddr,
    output logic [7:0]                            wdata
);
    import video_bus_pkg::*;

    localparam int TEXT_SIZE = COLS * ROWS;
    localparam int FONT_SIZE = 256 * GLYPH_ROWS;
    localparam int TEXT_AW   = $clog2(TEXT_SIZE);
    localparam int FONT_AW   = $clog2(FONT_SIZE);

    logic                  wr;
    logic [BUS_ADDR_W-1:0] offset;
    logic [BUS_ADDR_W-1:0] text_off;
    logic [BUS_ADDR_W-1:0] font_off;

    assign wr       = strobe & rw;
    assign offset   = addr - VIDEO_BASE;  // below base wraps high, misses every window
    assign text_off = offset - TEXT_OFFSET;
    assign font_off = offset - FONT_OFFSET;

    assign wdata = data[7:0];  // byte-wide registers and memories

    // ram writes land on the same edge that samples the bus
    assign text_we    = wr && (offset >= TEXT_OFFSET) && (text_off < TEXT_SIZE);
    assign text_waddr = text_off[TEXT_AW-1:0];
    assign font_we    = wr && (offset >= FONT_OFFSET) && (font_off < FONT_SIZE);
    assign font_waddr = font_off[FONT_AW-1:0];

    always_ff @(posedge clk_core) begin
        if (rst) begin
            ctl      <= CTL_RESET;
            cursor_x <= '0;
            cursor_y <= '0;
        end else if (wr) begin
            if (offset == REG_CTL)
                ctl <= wdata;
            if (offset == REG_CURSOR_X)
                cursor_x <= wdata;
            if (offset == REG_CURSOR_Y)
                cursor_y <= wdata;
        end
    end

endmodule

// ==== logic/video_timing_pkg.sv ====
package video_timing_pkg;

    // glyphs are one byte wide, bit 7 is the leftmost pixel
    localparam int GLYPH_W = 8;

    // default screen, 80x40 cells of 8x12 pixels
    localparam int DEF_COLS       = 80;
    localparam int DEF_ROWS       = 40;
    localparam int DEF_GLYPH_ROWS = 12;

    // horizontal porches and sync, in pixels
    localparam int DEF_H_FRONT = 16;
    localparam int DEF_H_SYNC  = 96;
    localparam int DEF_H_BACK  = 48;

    // vertical porches and sync, in lines
    localparam int DEF_V_FRONT = 10;
    localparam int DEF_V_SYNC  = 2;
    localparam int DEF_V_BACK  = 33;

    // text read, glyph read, pixel register
    localparam int RENDER_LATENCY = 3;

endpackage

// ==== run.sh ====
#!/bin/sh
# build and run the text video testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f verilog.f \
    --top-module text_video_tb -Mdir obj_dir -o text_video_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/text_video_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ERRORS FOUND" sim.log; then
    exit 1
fi
exit 0

// ==== sim/text_video_tb.sv ====
module text_video_tb;
    import video_bus_pkg::*;
    import video_timing_pkg::*;

    localparam logic [31:0] BASE = 32'h4000;
    localparam int COLS = 8;
    localparam int ROWS = 4;
    localparam int GROWS = 4;
    localparam int H_FP = 4;
    localparam int H_SW = 8;
    localparam int H_BP = 4;
    localparam int V_FP = 1;
    localparam int V_SW = 2;
    localparam int V_BP = 1;
    localparam int H_ACT = COLS * GLYPH_W;
    localparam int V_ACT = ROWS * GROWS;
    localparam int H_TOTAL = H_ACT + H_FP + H_SW + H_BP;
    localparam int V_TOTAL = V_ACT + V_FP + V_SW + V_BP;
    localparam int HS_START = H_ACT + H_FP;
    localparam int VS_START = V_ACT + V_FP;
    localparam int NUM_TESTS = 6;
    localparam int CYCLE_LIMIT = NUM_TESTS * 6 * H_TOTAL * V_TOTAL + 2000;

    logic clk_core, clk_vga, rst, strobe, rw;
    logic [BUS_ADDR_W-1:0] addr;
    logic [BUS_DATA_W-1:0] data;
    logic [2:0] vga_red, vga_green;
    logic [1:0] vga_blue;
    logic hsync, vsync;
    logic [7:0] vga_out;

    // shadow model of what software has written
    logic [7:0] text_m [COLS*ROWS];
    logic [7:0] font_m [256*GROWS];
    logic [7:0] ctl_m, cx_m, cy_m;
    logic [31:0] lfsr = 32'h6be9;

    // output position recovered from the syncs
    int px = 0;
    int py = 0;
    int cur_x, cur_ln;
    logic hs_prev = 1'b1;
    logic vs_prev = 1'b1;
    logic hlocked = 1'b0;
    logic vlocked = 1'b0;
    logic check_pix = 1'b0;
    logic hs_rise, vs_rise, in_act, hs_exp, vs_exp;
    logic [7:0] exp_pix;
    int frames = 0;
    int cycles = 0;
    int errors = 0;
    int start_errors = 0;
    int tests = 0;
    int failed = 0;
    string test_name = "reset";

    text_video #(
        .VIDEO_BASE(BASE), .COLS(COLS), .ROWS(ROWS), .GLYPH_ROWS(GROWS),
        .H_FRONT(H_FP), .H_SYNC(H_SW), .H_BACK(H_BP),
        .V_FRONT(V_FP), .V_SYNC(V_SW), .V_BACK(V_BP)
    ) u_text_video (
        .clk_core(clk_core), .clk_vga(clk_vga), .rst(rst), .strobe(strobe), .rw(rw),
        .addr(addr), .data(data), .vga_red(vga_red), .vga_green(vga_green),
        .vga_blue(vga_blue), .hsync(hsync), .vsync(vsync)
    );

    assign vga_out = {vga_red, vga_green, vga_blue};

    initial begin
        clk_core = 1'b0;
        forever #2 clk_core = ~clk_core;
    end

    initial begin
        clk_vga = 1'b0;
        #1;
        forever #2 clk_vga = ~clk_vga;
    end

    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};  // x^32+x^22+x^2+x+1
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [7:0] model_pixel(input int x, input int y);
        logic [7:0] ch;
        logic [7:0] bits;
        logic inv;
        logic [2:0] c;
        if (x >= H_ACT || y >= V_ACT || !ctl_m[CTL_ENABLE])
            return 8'h00;
        ch = text_m[(y / GROWS) * COLS + x / GLYPH_W];
        bits = font_m[ch * GROWS + y % GROWS];
        inv = ctl_m[CTL_CURSOR] && (x / GLYPH_W == cx_m) && (y / GROWS == cy_m);
        c = (bits[GLYPH_W - 1 - x % GLYPH_W] ^ inv) ? ctl_m[2:0] : ctl_m[5:3];
        return {{3{c[2]}}, {3{c[1]}}, {2{c[0]}}};
    endfunction

    // hsync rise marks the first back porch pixel and vsync rise the first pixel of the last line
    always_comb begin
        hs_rise = !hs_prev && hsync;
        vs_rise = !vs_prev && vsync;
        cur_x = hs_rise ? HS_START + H_SW : (px + 1) % H_TOTAL;
        if (vs_rise)
            cur_ln = VS_START + V_SW;
        else if (cur_x == 0)
            cur_ln = (py + 1) % V_TOTAL;
        else
            cur_ln = py;
        in_act = (cur_x < H_ACT) && (cur_ln < V_ACT);
        hs_exp = !(cur_x >= HS_START && cur_x < HS_START + H_SW);
        vs_exp = !(cur_ln >= VS_START && cur_ln < VS_START + V_SW);
        exp_pix = model_pixel(cur_x, cur_ln);
    end

    always @(negedge clk_vga) begin
        hs_prev <= hsync;
        vs_prev <= vsync;
        px <= cur_x;
        py <= cur_ln;
        if (hs_rise)
            hlocked <= 1'b1;
        if (vs_rise && hlocked)
            vlocked <= 1'b1;
        if (vlocked && cur_x == 0 && cur_ln == 0)
            frames <= frames + 1;
    end

    always @(posedge clk_vga) begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            $display("timeout: run stopped after %0d video cycles", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic report_value(input string what, input logic [7:0] exp, input logic [7:0] act);
        errors++;
        $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp, act);
    endtask

    task automatic report_plain(input string what);
        errors++;
        $display("%s: %s", test_name, what);
    endtask

    hsync_level: assert property (@(negedge clk_vga) hlocked |-> hsync == hs_exp)
        else report_value("hsync", $sampled(hs_exp), $sampled(hsync));
    hsync_period: assert property (@(negedge clk_vga)
        (hlocked && hs_rise) |-> px == HS_START + H_SW - 1)
        else report_plain("hsync rose off the line period");
    vsync_level: assert property (@(negedge clk_vga) vlocked |-> vsync == vs_exp)
        else report_value("vsync", $sampled(vs_exp), $sampled(vsync));
    vsync_period: assert property (@(negedge clk_vga)
        (vlocked && vs_rise) |-> (py == VS_START + V_SW - 1 && cur_x == 0))
        else report_plain("vsync rose off the frame period");
    blank_level: assert property (@(negedge clk_vga) (vlocked && !in_act) |-> vga_out == 8'h00)
        else report_value("blanking", 8'h00, $sampled(vga_out));
    pixel_value: assert property (@(negedge clk_vga)
        (vlocked && check_pix && in_act) |-> vga_out == exp_pix)
        else report_value("pixel", $sampled(exp_pix), $sampled(vga_out));

    task automatic bus_write(input logic [31:0] a, input logic [7:0] d);
        logic [31:0] off;
        @(negedge clk_core);
        strobe = 1'b1;
        rw = 1'b1;
        addr = a;
        data = {24'(lfsr_bits(24)), d};  // upper bytes are don't care
        off = a - BASE;
        if (off == REG_CTL)
            ctl_m = d;
        else if (off == REG_CURSOR_X)
            cx_m = d;
        else if (off == REG_CURSOR_Y)
            cy_m = d;
        else if (off >= TEXT_OFFSET && off - TEXT_OFFSET < COLS * ROWS)
            text_m[off - TEXT_OFFSET] = d;
        else if (off >= FONT_OFFSET && off - FONT_OFFSET < 256 * GROWS)
            font_m[off - FONT_OFFSET] = d;
    endtask

    task automatic wait_frames(input int n);
        int target;
        target = frames + n;
        while (frames < target)
            @(negedge clk_vga);
    endtask

    // writes show from the second full frame on
    task automatic check_frame();
        @(negedge clk_core);
        strobe = 1'b0;
        rw = 1'b0;
        wait_frames(2);
        check_pix = 1'b1;
        wait_frames(1);
        check_pix = 1'b0;
    endtask

    task automatic finish_test();
        tests++;
        if (errors != start_errors)
            failed++;
        $display("test %s done, %0d errors", test_name, errors - start_errors);
        start_errors = errors;
    endtask

    function automatic logic [7:0] random_ctl(input logic cursor);
        logic [2:0] bg;
        logic [2:0] fg;
        bg = 3'(lfsr_bits(3));
        fg = 3'(lfsr_bits(3));
        if (fg == bg)
            fg = ~bg;
        return {1'b1, cursor, bg, fg};
    endfunction

    initial begin
        logic [7:0] ch;
        logic [7:0] cx;
        int idle_cycles;
        rst = 1'b1;
        strobe = 1'b0;
        rw = 1'b0;
        addr = '0;
        data = '0;
        for (int i = 0; i < COLS * ROWS; i++)
            text_m[i] = 8'h20;
        for (int i = 0; i < 256 * GROWS; i++)
            font_m[i] = 8'h00;
        ctl_m = CTL_RESET;
        cx_m = '0;
        cy_m = '0;

        test_name = "sync";
        repeat (5) @(negedge clk_core);
        assert (hsync && vsync && vga_out == 8'h00)
            else report_plain("syncs or color not idle during reset");
        rst = 1'b0;
        // outputs stay idle until the first line reaches its sync pulse
        idle_cycles = 0;
        @(negedge clk_vga);
        while (hsync && idle_cycles <= HS_START + RENDER_LATENCY) begin
            assert (vsync && vga_out == 8'h00)
                else report_plain("vsync or color not idle after reset");
            idle_cycles++;
            @(negedge clk_vga);
        end
        assert (idle_cycles == HS_START + RENDER_LATENCY)
            else report_plain("first hsync pulse after reset did not start at the sync position");
        wait (vlocked);
        wait_frames(2);
        finish_test();

        test_name = "blanking";
        bus_write(BASE + REG_CTL, 8'hb8);  // white background
        check_frame();
        finish_test();

        test_name = "text";
        bus_write(BASE + REG_CTL, random_ctl(1'b0));
        for (int i = 0; i < COLS * ROWS; i++) begin
            ch = 8'(lfsr_bits(8));
            bus_write(BASE + TEXT_OFFSET + i, ch);
            for (int g = 0; g < GROWS; g++)
                bus_write(BASE + FONT_OFFSET + ch * GROWS + g, 8'(lfsr_bits(8)));
        end
        check_frame();
        finish_test();

        test_name = "control";
        bus_write(BASE + REG_CTL, random_ctl(1'b0));
        check_frame();
        bus_write(BASE + REG_CTL, {1'b0, 7'(lfsr_bits(7))});
        check_frame();
        finish_test();

        test_name = "cursor";
        bus_write(BASE + REG_CTL, random_ctl(1'b1));
        cx = 8'(lfsr_bits(3));
        bus_write(BASE + REG_CURSOR_X, cx);
        bus_write(BASE + REG_CURSOR_Y, 8'(lfsr_bits(2)));
        check_frame();
        cx = 8'((cx + 1 + lfsr_bits(2)) % COLS);  // always moves
        bus_write(BASE + REG_CURSOR_X, cx);
        bus_write(BASE + REG_CURSOR_Y, 8'(lfsr_bits(2)));
        check_frame();
        finish_test();

        test_name = "ignored";
        bus_write(BASE + TEXT_OFFSET + COLS * ROWS + lfsr_bits(4), 8'(lfsr_bits(8)));
        bus_write(BASE + FONT_OFFSET + 256 * GROWS + lfsr_bits(4), 8'(lfsr_bits(8)));
        bus_write(BASE + 3, 8'(lfsr_bits(8)));
        bus_write(BASE + TEXT_OFFSET - 1, 8'(lfsr_bits(8)));
        bus_write(BASE + 'h3000, 8'(lfsr_bits(8)));
        bus_write(BASE - 1, 8'(lfsr_bits(8)));
        check_frame();
        finish_test();

        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== verilog.f ====
logic/video_bus_pkg.sv
logic/video_timing_pkg.sv
logic/video_regs.sv
logic/dual_clock_ram.sv
logic/vga_timing.sv
logic/text_renderer.sv
logic/text_video.sv
sim/text_video_tb.sv
